// ==== verilog.f ====
+incdir+hw
hw/hprg_pkg.sv
hw/hprg_chnl_if.sv
hw/hprg_dispatch.sv
hw/hprg_sink.sv
hw/hprg_err_collect.sv
hw/hprg_top.sv
test/hprg_assertions.sv
test/hprg_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# Builds the probe checker testbench with Verilator and runs it.
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal -f verilog.f --top-module hprg_tb -o hprg_sim
if [ $? -ne 0 ]; then
	echo "Verilator build failed"
	exit 1
fi

out=$(./obj_dir/hprg_sim 2>&1)
status=$?
echo "$out"
if [ $status -ne 0 ]; then
	echo "Simulation exited with status $status"
	exit 1
fi

if echo "$out" | grep -q "^Testbench passed$"; then
	exit 0
fi
exit 1

// ==== test/hprg_tb.sv ====
`include "hprg_config.svh"

module hprg_tb;

	localparam int NUM_MSGS = 64;
	localparam int NUM_CLEAN = 24;
	localparam int TIMEOUT = NUM_MSGS * 12 + 100;
	localparam int LANE_W = $clog2(`HPRG_NUM_SINKS);

	logic gch_clk;
	logic gch_reset;
	logic gch_ready;
	logic in_req;
	logic [`HPRG_ADDR_SIZE-1:0] in_src;
	logic [`HPRG_ADDR_SIZE-1:0] in_dst;
	logic [`HPRG_DATA_SIZE-1:0] in_dat;
	logic [`HPRG_REDUN_SIZE-1:0] in_red;
	logic in_ack;
	logic err_valid;
	logic [LANE_W-1:0] err_lane;
	logic [2:0] err_kind;
	logic [`HPRG_ADDR_SIZE-1:0] err_src;
	logic [`HPRG_ADDR_SIZE-1:0] err_dst;
	logic [`HPRG_DATA_SIZE-1:0] err_dat;

	logic [15:0] lfsr;
	logic [`HPRG_DATA_SIZE-1:0] counter [`HPRG_NUM_SINKS]; // Next in-order data per lane.
	logic [`HPRG_NUM_SINKS-1:0] seen;
	logic ready_up;
	hprg_pkg::msg_t sent_msg [$];
	int sent_lane [$];
	int value_errs;
	int other_errs;
	int cycles;

	hprg_top dut (.*);

	initial begin
		gch_clk = 1'b0;
		forever #10 gch_clk = ~gch_clk;
	end

	// Galois LFSR, stepped once for every bit taken.
	function automatic int next_bits(input int n);
		int v;
		v = 0;
		for (int i = 0; i < n; i++) begin
			lfsr = lfsr[0] ? ((lfsr >> 1) ^ 16'hb400) : (lfsr >> 1);
			v = (v << 1) | int'(lfsr[0]);
		end
		return v;
	endfunction

	// Five nibbles of src, dst and dat XORed together.
	function automatic logic [3:0] expect_redun(input hprg_pkg::msg_t m);
		logic [19:0] v;
		v = {m.src, m.dst, m.dat};
		return v[19:16] ^ v[15:12] ^ v[11:8] ^ v[7:4] ^ v[3:0];
	endfunction

	function automatic int route_lane(input logic [`HPRG_ADDR_SIZE-1:0] dst);
		int ofs;
		ofs = int'(dst) - `HPRG_SINK_BASE_ADDR;
		return (ofs >= 0 && ofs < `HPRG_NUM_SINKS) ? ofs : 0; // Strays land on lane 0.
	endfunction

	// First error a lane should hold, replayed over every message routed to it.
	function automatic hprg_pkg::err_kind_t expect_first_err(input int lane,
			output hprg_pkg::msg_t bad);
		hprg_pkg::err_kind_t k;
		hprg_pkg::msg_t m;
		logic [`HPRG_DATA_SIZE-1:0] prev;
		k = hprg_pkg::err_none;
		prev = '1;
		bad = '0;
		for (int i = 0; i < sent_msg.size(); i++) begin
			m = sent_msg[i];
			if (k == hprg_pkg::err_none && sent_lane[i] == lane) begin
				if (int'(m.dst) != `HPRG_SINK_BASE_ADDR + lane) k = hprg_pkg::err_bad_dst;
				else if (int'(m.src) != `HPRG_PROBE_SRC_ADDR) k = hprg_pkg::err_bad_src;
				else if (m.red != expect_redun(m)) k = hprg_pkg::err_bad_redun;
				else if (prev != '1 && m.dat != prev + 1'b1) k = hprg_pkg::err_bad_seq;
				else prev = m.dat;
				if (k != hprg_pkg::err_none) bad = m;
			end
		end
		return k;
	endfunction

	task automatic check_kind(input hprg_pkg::err_kind_t exp, input hprg_pkg::err_kind_t act);
		if (act !== exp) begin
			value_errs++;
			$display("FAIL err_kind expected 0x%0h got 0x%0h", exp, act);
		end
	endtask

	// Reported messages reach the top level without their redundancy code.
	task automatic check_msg(input hprg_pkg::msg_t exp, input hprg_pkg::msg_t act);
		if ({act.src, act.dst, act.dat} !== {exp.src, exp.dst, exp.dat}) begin
			value_errs++;
			$display("FAIL err_src/err_dst/err_dat expected 0x%0h 0x%0h 0x%0h got 0x%0h 0x%0h 0x%0h",
				exp.src, exp.dst, exp.dat, act.src, act.dst, act.dat);
		end
	endtask

	task automatic check_lane(input int exp, input logic [LANE_W-1:0] act);
		if (int'(act) != exp) begin
			value_errs++;
			$display("FAIL err_lane expected 0x%0h got 0x%0h", exp, act);
		end
	endtask

	task automatic compare_report();
		int lane;
		hprg_pkg::err_kind_t exp_kind;
		hprg_pkg::msg_t exp_msg;
		lane = (sent_lane.size() > 0) ? sent_lane[$] : 0; // Only one message is in flight.
		check_lane(lane, err_lane);
		if (seen[err_lane]) begin
			other_errs++;
			$display("Lane %0d reported an error a second time", err_lane);
		end
		seen[err_lane] = 1'b1;
		exp_kind = expect_first_err(lane, exp_msg);
		exp_msg.red = '0;
		check_kind(exp_kind, hprg_pkg::err_kind_t'(err_kind));
		check_msg(exp_msg, {err_src, err_dst, err_dat, `HPRG_REDUN_SIZE'(0)});
	endtask

	always @(negedge gch_clk) begin
		if (!gch_reset && err_valid === 1'b1) compare_report();
		if (ready_up && gch_ready !== 1'b1) begin
			other_errs++;
			$display("gch_ready dropped after it had risen");
		end
	end

	// Picks a lane and, once corruption is allowed, one fault in four.
	task automatic make_msg(input bit corrupt, output hprg_pkg::msg_t m);
		int lane;
		int pick;
		lane = next_bits(LANE_W);
		pick = corrupt ? next_bits(4) : 15;
		m.src = `HPRG_ADDR_SIZE'(`HPRG_PROBE_SRC_ADDR);
		m.dst = `HPRG_ADDR_SIZE'(`HPRG_SINK_BASE_ADDR + lane);
		m.dat = counter[lane];
		case (pick)
			0: m.src = m.src ^ `HPRG_ADDR_SIZE'(1 + next_bits(5));
			1: m.dat = counter[lane] + `HPRG_DATA_SIZE'(2 + next_bits(2));
			2: m.dst = `HPRG_ADDR_SIZE'(`HPRG_SINK_BASE_ADDR + `HPRG_NUM_SINKS + next_bits(4));
			default: begin
				if (pick > 3) counter[lane] = counter[lane] + 1'b1;
			end
		endcase
		m.red = expect_redun(m);
		if (pick == 3) m.red = m.red ^ `HPRG_REDUN_SIZE'(1 + next_bits(3));
	endtask

	task automatic send_msg(input hprg_pkg::msg_t m);
		{in_src, in_dst, in_dat, in_red} = m;
		in_req = 1'b1;
		do begin
			@(posedge gch_clk);
			#2;
		end while (!in_ack);
		// The sink has checked the message by the time in_ack is high.
		sent_msg.push_back(m);
		sent_lane.push_back(route_lane(m.dst));
		in_req = 1'b0;
		do begin
			@(posedge gch_clk);
			#2;
		end while (in_ack);
	endtask

	initial begin
		hprg_pkg::msg_t m;
		hprg_pkg::msg_t bad;
		int ready_wait;
		lfsr = 16'd62;
		value_errs = 0;
		other_errs = 0;
		seen = '0;
		ready_up = 1'b0;
		gch_reset = 1'b1;
		in_req = 1'b0;
		{in_src, in_dst, in_dat, in_red} = '0;
		for (int l = 0; l < `HPRG_NUM_SINKS; l++) begin
			counter[l] = `HPRG_DATA_SIZE'(251 + l); // Close to the top so each lane wraps.
		end
		repeat (3) @(posedge gch_clk);
		#2;
		if (gch_ready !== 1'b0) begin
			other_errs++;
			$display("gch_ready is high during reset");
		end
		gch_reset = 1'b0;
		ready_wait = 0;
		while (gch_ready !== 1'b1) begin
			@(posedge gch_clk);
			#2;
			ready_wait++;
		end
		if (ready_wait != 2) begin
			other_errs++;
			$display("gch_ready rose %0d cycles after reset instead of 2", ready_wait);
		end
		ready_up = 1'b1;
		if (in_ack !== 1'b0) begin
			other_errs++;
			$display("in_ack is high before any request was sent");
		end
		for (int i = 0; i < NUM_MSGS; i++) begin
			make_msg(i >= NUM_CLEAN, m);
			send_msg(m);
		end
		repeat (2 * `HPRG_NUM_SINKS) @(posedge gch_clk);
		for (int l = 0; l < `HPRG_NUM_SINKS; l++) begin
			if (expect_first_err(l, bad) != hprg_pkg::err_none && !seen[l]) begin
				other_errs++;
				$display("Lane %0d never reported the error it should hold", l);
			end
		end
		$display("Errors: %0d wrong values, %0d other failures", value_errs, other_errs);
		if (value_errs + other_errs == 0) begin
			$display("Testbench passed");
		end else begin
			$display("Testbench failed");
		end
		$finish;
	end

	initial begin
		cycles = 0;
		while (cycles < TIMEOUT) begin
			@(posedge gch_clk);
			cycles++;
		end
		$display("The run did not finish within %0d cycles", TIMEOUT);
		$display("Errors: %0d wrong values, %0d other failures", value_errs, other_errs + 1);
		$display("Testbench failed");
		$finish;
	end

endmodule

// ==== test/hprg_assertions.sv ====
module hprg_assertions (
	input logic gch_clk,
	input logic gch_reset,
	input logic gch_ready,
	input logic in_req,
	input logic in_ack,
	input logic err_valid
);

	// The host held in_req on the cycle before in_ack rose.
	a_ack_after_req: assert property (@(posedge gch_clk) disable iff (gch_reset)
		$rose(in_ack) |-> $past(in_req))
		else $error("in_ack rose without a request from the host");

	a_valid_pulse: assert property (@(posedge gch_clk) disable iff (gch_reset)
		err_valid |=> !err_valid)
		else $error("err_valid stayed high for more than one cycle");

	// No lane can finish a handshake before it has left init.
	a_no_ack_before_ready: assert property (@(posedge gch_clk) disable iff (gch_reset)
		!gch_ready |-> !in_ack)
		else $error("in_ack was high before gch_ready");

endmodule

bind hprg_top hprg_assertions u_assertions (
	.gch_clk(gch_clk),
	.gch_reset(gch_reset),
	.gch_ready(gch_ready),
	.in_req(in_req),
	.in_ack(in_ack),
	.err_valid(err_valid)
);

// ==== hw/hprg_top.sv ====
`include "hprg_config.svh"

module hprg_top (
	input logic gch_clk,
	input logic gch_reset,
	output logic gch_ready,
	input logic in_req,
	input logic [`HPRG_ADDR_SIZE-1:0] in_src,
	input logic [`HPRG_ADDR_SIZE-1:0] in_dst,
	input logic [`HPRG_DATA_SIZE-1:0] in_dat,
	input logic [`HPRG_REDUN_SIZE-1:0] in_red,
	output logic in_ack,
	output logic err_valid,
	output logic [$clog2(`HPRG_NUM_SINKS)-1:0] err_lane,
	output logic [2:0] err_kind,
	output logic [`HPRG_ADDR_SIZE-1:0] err_src,
	output logic [`HPRG_ADDR_SIZE-1:0] err_dst,
	output logic [`HPRG_DATA_SIZE-1:0] err_dat
);

	hprg_pkg::msg_t in_msg;
	hprg_pkg::msg_t err_msg;
	hprg_pkg::err_kind_t kind;
	logic [`HPRG_NUM_SINKS-1:0] lane_ready;

	hprg_msg_if lane_if [`HPRG_NUM_SINKS] ();
	hprg_err_if err_if [`HPRG_NUM_SINKS] ();

	assign in_msg.src = in_src;
	assign in_msg.dst = in_dst;
	assign in_msg.dat = in_dat;
	assign in_msg.red = in_red;

	hprg_dispatch u_dispatch (
		.gch_clk(gch_clk),
		.gch_reset(gch_reset),
		.in_req(in_req),
		.in_msg(in_msg),
		.in_ack(in_ack),
		.lanes(lane_if)
	);

	for (genvar i = 0; i < `HPRG_NUM_SINKS; i++) begin : g_sink
		hprg_sink #(
			.my_addr(`HPRG_ADDR_SIZE'(`HPRG_SINK_BASE_ADDR + i))
		) u_sink (
			.gch_clk(gch_clk),
			.gch_reset(gch_reset),
			.rcv(lane_if[i]),
			.err(err_if[i])
		);
		assign lane_ready[i] = err_if[i].ready;
	end

	hprg_err_collect u_collect (
		.gch_clk(gch_clk),
		.gch_reset(gch_reset),
		.errs(err_if),
		.err_valid(err_valid),
		.err_lane(err_lane),
		.err_kind(kind),
		.err_msg(err_msg)
	);

	assign err_kind = kind;
	assign err_src = err_msg.src;
	assign err_dst = err_msg.dst;
	assign err_dat = err_msg.dat;
	assign gch_ready = &lane_ready; // Ready once every lane has left init.

endmodule

// ==== hw/hprg_err_collect.sv ====
`include "hprg_config.svh"

module hprg_err_collect (
	input logic gch_clk,
	input logic gch_reset,
	hprg_err_if.drain errs [`HPRG_NUM_SINKS],
	output logic err_valid,
	output logic [$clog2(`HPRG_NUM_SINKS)-1:0] err_lane,
	output hprg_pkg::err_kind_t err_kind,
	output hprg_pkg::msg_t err_msg
);

	localparam int LANE_W = $clog2(`HPRG_NUM_SINKS);

	logic [LANE_W-1:0] ptr;
	logic [`HPRG_NUM_SINKS-1:0] reported;
	logic [`HPRG_NUM_SINKS-1:0] taken_r;
	logic [`HPRG_NUM_SINKS-1:0] err_vec;
	hprg_pkg::err_kind_t kind_arr [`HPRG_NUM_SINKS];
	hprg_pkg::msg_t msg_arr [`HPRG_NUM_SINKS];

	for (genvar i = 0; i < `HPRG_NUM_SINKS; i++) begin : g_lane
		assign err_vec[i] = errs[i].error;
		assign kind_arr[i] = errs[i].kind;
		assign msg_arr[i] = errs[i].msg;
		assign errs[i].taken = taken_r[i];
	end

	always_ff @(posedge gch_clk) begin
		if (gch_reset) begin
			ptr <= '0;
			reported <= '0;
			taken_r <= '0;
			err_valid <= 1'b0;
		end else begin
			ptr <= (ptr == LANE_W'(`HPRG_NUM_SINKS - 1)) ? '0 : ptr + 1'b1;
			err_valid <= 1'b0;
			taken_r <= '0;
			// A lane is reported once, the first time the scan finds its error.
			if (err_vec[ptr] && !reported[ptr]) begin
				reported[ptr] <= 1'b1;
				taken_r[ptr] <= 1'b1;
				err_valid <= 1'b1;
				err_lane <= ptr;
				err_kind <= kind_arr[ptr];
				err_msg <= msg_arr[ptr];
			end
		end
	end

endmodule

// ==== hw/hprg_sink.sv ====
`include "hprg_config.svh"

module hprg_sink #(
	parameter logic [`HPRG_ADDR_SIZE-1:0] my_addr = `HPRG_SINK_BASE_ADDR
) (
	input logic gch_clk,
	input logic gch_reset,
	hprg_msg_if.receiver rcv,
	hprg_err_if.reporter err
);

	localparam int CNT_W = $clog2(`HPRG_REQ_CKS + 1);

	hprg_pkg::sink_state_t state;
	logic [CNT_W-1:0] cnt;
	logic req_seen;
	hprg_pkg::msg_t msg_r;
	logic [`HPRG_REDUN_SIZE-1:0] red_r;
	logic [`HPRG_DATA_SIZE-1:0] prev_dat;
	logic ack_r;
	logic ready_r;
	logic err_flag;
	hprg_pkg::err_kind_t err_kind_r;
	hprg_pkg::msg_t err_msg_r;

	// Debounce counts consecutive high samples of req and saturates.
	always_ff @(posedge gch_clk) begin
		if (gch_reset || !rcv.req) begin
			cnt <= '0;
		end else if (cnt != CNT_W'(`HPRG_REQ_CKS)) begin
			cnt <= cnt + 1'b1;
		end
	end

	assign req_seen = rcv.req && (cnt >= CNT_W'(`HPRG_REQ_CKS - 1));

	always_ff @(posedge gch_clk) begin
		if (gch_reset) begin
			state <= hprg_pkg::s_init;
			ack_r <= 1'b0;
			ready_r <= 1'b0;
			err_flag <= 1'b0;
			err_kind_r <= hprg_pkg::err_none;
			prev_dat <= '1; // The first message may carry any data.
		end else begin
			if (state != hprg_pkg::s_init) ready_r <= 1'b1;
			case (state)
				hprg_pkg::s_init: state <= hprg_pkg::s_idle;
				hprg_pkg::s_idle: begin
					if (req_seen) state <= hprg_pkg::s_capture;
				end
				hprg_pkg::s_capture: begin
					msg_r <= rcv.msg;
					state <= hprg_pkg::s_redun;
				end
				hprg_pkg::s_redun: begin
					red_r <= hprg_pkg::calc_redun(msg_r);
					state <= hprg_pkg::s_check;
				end
				hprg_pkg::s_check: begin
					// Once an error is held the lane only acknowledges.
					if (!err_flag) begin
						if (msg_r.dst != my_addr) begin
							err_flag <= 1'b1;
							err_kind_r <= hprg_pkg::err_bad_dst;
							err_msg_r <= msg_r;
						end else if (msg_r.src != `HPRG_ADDR_SIZE'(`HPRG_PROBE_SRC_ADDR)) begin
							err_flag <= 1'b1;
							err_kind_r <= hprg_pkg::err_bad_src;
							err_msg_r <= msg_r;
						end else if (msg_r.red != red_r) begin
							err_flag <= 1'b1;
							err_kind_r <= hprg_pkg::err_bad_redun;
							err_msg_r <= msg_r;
						end else if (prev_dat != '1 && msg_r.dat != prev_dat + 1'b1) begin
							err_flag <= 1'b1;
							err_kind_r <= hprg_pkg::err_bad_seq;
							err_msg_r <= msg_r;
						end else begin
							prev_dat <= msg_r.dat;
						end
					end
					ack_r <= 1'b1;
					state <= hprg_pkg::s_ack;
				end
				hprg_pkg::s_ack: begin
					if (!req_seen) begin
						ack_r <= 1'b0;
						state <= hprg_pkg::s_idle;
					end
				end
				default: state <= hprg_pkg::s_idle;
			endcase
		end
	end

	assign rcv.ack = ack_r;

	assign err.error = err_flag;
	assign err.kind = err_kind_r;
	assign err.msg = err_msg_r;
	assign err.ready = ready_r;

endmodule

// ==== hw/hprg_dispatch.sv ====
`include "hprg_config.svh"

module hprg_dispatch (
	input logic gch_clk,
	input logic gch_reset,
	input logic in_req,
	input hprg_pkg::msg_t in_msg,
	output logic in_ack,
	hprg_msg_if.sender lanes [`HPRG_NUM_SINKS]
);

	localparam int LANE_W = $clog2(`HPRG_NUM_SINKS);

	hprg_pkg::disp_state_t state;
	hprg_pkg::msg_t msg_r;
	logic [LANE_W-1:0] sel;
	logic [LANE_W-1:0] sel_nxt;
	logic lane_req;
	logic [`HPRG_NUM_SINKS-1:0] lane_ack;
	logic [`HPRG_ADDR_SIZE-1:0] ofs;

	// Addresses below the base wrap to a large offset, so one compare covers both ends.
	assign ofs = in_msg.dst - `HPRG_ADDR_SIZE'(`HPRG_SINK_BASE_ADDR);
	assign sel_nxt = (ofs < `HPRG_NUM_SINKS) ? ofs[LANE_W-1:0] : '0;

	for (genvar i = 0; i < `HPRG_NUM_SINKS; i++) begin : g_lane
		assign lanes[i].req = lane_req && (sel == LANE_W'(i));
		assign lanes[i].msg = msg_r;
		assign lane_ack[i] = lanes[i].ack;
	end

	always_ff @(posedge gch_clk) begin
		if (gch_reset) begin
			state <= hprg_pkg::d_idle;
			lane_req <= 1'b0;
			in_ack <= 1'b0;
			sel <= '0;
		end else begin
			case (state)
				hprg_pkg::d_idle: begin
					if (in_req) begin
						msg_r <= in_msg;
						sel <= sel_nxt;
						lane_req <= 1'b1;
						state <= hprg_pkg::d_forward;
					end
				end
				hprg_pkg::d_forward: begin
					if (lane_ack[sel]) begin
						in_ack <= 1'b1; // The sink has finished with the message.
						state <= hprg_pkg::d_hold;
					end
				end
				hprg_pkg::d_hold: begin
					if (!in_req) begin
						lane_req <= 1'b0;
						state <= hprg_pkg::d_release;
					end
				end
				hprg_pkg::d_release: begin
					// Host side closes only once the lane has let go of ack.
					if (!lane_ack[sel]) begin
						in_ack <= 1'b0;
						state <= hprg_pkg::d_idle;
					end
				end
				default: state <= hprg_pkg::d_idle;
			endcase
		end
	end

endmodule

// ==== hw/hprg_chnl_if.sv ====
// Four-phase message channel. msg may only change while req and ack are both low.
interface hprg_msg_if;
	logic req;
	logic ack;
	hprg_pkg::msg_t msg;

	modport sender (output req, output msg, input ack);
	modport receiver (input req, input msg, output ack);
endinterface

// Sticky error record of one sink, drained by the collector.
interface hprg_err_if;
	logic error;
	hprg_pkg::err_kind_t kind;
	hprg_pkg::msg_t msg;
	logic taken; // One-cycle pulse when the collector has reported this lane.
	logic ready;

	modport reporter (output error, output kind, output msg, output ready, input taken);
	modport drain (input error, input kind, input msg, input ready, output taken);
endinterface

// ==== hw/hprg_pkg.sv ====
`include "hprg_config.svh"

package hprg_pkg;

	typedef struct packed {
		logic [`HPRG_ADDR_SIZE-1:0] src;
		logic [`HPRG_ADDR_SIZE-1:0] dst;
		logic [`HPRG_DATA_SIZE-1:0] dat;
		logic [`HPRG_REDUN_SIZE-1:0] red;
	} msg_t;

	typedef enum logic [2:0] {
		s_init, s_idle, s_capture, s_redun, s_check, s_ack
	} sink_state_t;

	typedef enum logic [1:0] {d_idle, d_forward, d_hold, d_release} disp_state_t;

	typedef enum logic [2:0] {
		err_none, err_bad_dst, err_bad_src, err_bad_redun, err_bad_seq
	} err_kind_t;

	// XOR of all redundancy-sized slices of src, dst and dat taken together.
	function automatic logic [`HPRG_REDUN_SIZE-1:0] calc_redun(input msg_t m);
		logic [2*`HPRG_ADDR_SIZE+`HPRG_DATA_SIZE-1:0] bits;
		logic [`HPRG_REDUN_SIZE-1:0] r;
		bits = {m.src, m.dst, m.dat};
		r = '0;
		for (int i = 0; i < $bits(bits); i += `HPRG_REDUN_SIZE) begin
			r ^= bits[i +: `HPRG_REDUN_SIZE];
		end
		return r;
	endfunction

endpackage

// ==== hw/hprg_config.svh ====
`ifndef HPRG_CONFIG_SVH
`define HPRG_CONFIG_SVH

// Field widths of a probe message.
`define HPRG_ADDR_SIZE 6
`define HPRG_DATA_SIZE 8
`define HPRG_REDUN_SIZE 4

// Sink lanes and their addresses. Lane i answers at base plus i.
`define HPRG_NUM_SINKS 4
`define HPRG_SINK_BASE_ADDR 8

`define HPRG_PROBE_SRC_ADDR 3 // Only probe source the sinks accept.

// Consecutive cycles a request must be seen high before a sink takes it.
`define HPRG_REQ_CKS 2

`endif
